// File: bench/llc_lookup_tb.sv
module llc_lookup_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import llc_pkg::*;

    localparam int WAYS = 8;
    localparam int SETS = 16;
    localparam int RESET_CYCLES = 10;
    localparam int N_RESET = 8;
    localparam int N_RW = 20;
    localparam int N_VICTIM = 12;
    localparam int N_ROT = 10;
    localparam int N_MIX = 16;
    localparam int FILL_LEN = 2 * WAYS;   // SELECT and ENTRY write per way.
    localparam int LOOK_LEN = 3;          // SELECT, LOOKUP, RESULT.
    localparam int N_ACCESSES = 3 * N_RESET + 4 * N_RW + 4 * FILL_LEN + 10 + 2 * LOOK_LEN
        + N_VICTIM * (FILL_LEN + 2 * LOOK_LEN) + (N_ROT + 1) * LOOK_LEN
        + N_MIX * (FILL_LEN + LOOK_LEN);
    localparam int TIMEOUT_CYCLES = 20 * N_ACCESSES + RESET_CYCLES;
    localparam llc_tag_t POOL_BASE = 20'ha5c30;   // Four tags, so mixed sets hit often.
    localparam llc_tag_t MISS_BASE = 20'h1f000;
    localparam llc_tag_t HIT_TAG = 20'h50f0f;
    localparam llc_tag_t STALE_TAG = 20'h61234;

    logic        clk;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat_w;
    logic [3:0]  sel;
    logic [31:0] dat_r;
    logic        ack;
    logic        ack_prev;
    logic        req_seen;   // cyc and stb at the last rising edge.
    logic [31:0] lfsr;
    logic [31:0] exp_mask;
    logic [31:0] exp_data;
    string       exp_name;
    int          cycle_count = 0;
    llc_state_t  state_m [SETS][WAYS];
    llc_tag_t    tag_m [SETS][WAYS];
    int          ptr_m [SETS];

    llc_lookup_top #(.WAYS(WAYS), .SETS(SETS)) dut0 (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Only the fields the model knows are compared.
    assert property (@(negedge clk) disable iff (!rst) !ack || (dat_r & exp_mask) == exp_data)
    else begin
        $display("CHECK FAILED at %0t ns: %s = %h, expected %h",
                 $time, exp_name, dat_r & exp_mask, exp_data);
        stop_failed();
    end

    assert property (@(negedge clk) disable iff (!rst) !ack || req_seen)
    else begin
        $display("ack was raised at %0t ns with no access in progress", $time);
        stop_failed();
    end

    assert property (@(negedge clk) disable iff (!rst) !(ack && ack_prev))
    else begin
        $display("ack stayed high for more than one cycle at %0t ns", $time);
        stop_failed();
    end

    always @(negedge clk) begin
        ack_prev <= ack;
    end

    always @(posedge clk) begin
        req_seen <= cyc && stb;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("The run reached its limit of %0d cycles without finishing", cycle_count);
            stop_failed();
        end
    end

    task automatic stop_failed();
        $display("TEST FAIL");
        $fatal(1, "Stopped at the first error.");
    endtask

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
    endtask

    // One classic cycle, driven on the falling edge; latency counts cycles to ack.
    task automatic bus_access(input logic wr, input logic [1:0] rg, input logic [31:0] wdata,
                              input int latency, input logic [31:0] mask,
                              input logic [31:0] want, input string name);
        int waited;
        @(negedge clk);
        exp_mask = mask;
        exp_data = want & mask;
        exp_name = name;
        cyc = 1'b1;
        stb = 1'b1;
        we = wr;
        adr = {28'd0, rg, 2'b00};
        dat_w = wdata;
        sel = 4'hf;
        @(negedge clk);
        waited = 1;
        while (!ack) begin
            @(negedge clk);
            waited++;
        end
        assert (waited == latency) else begin
            $display("CHECK FAILED at %0t ns: ack latency = %0d, expected %0d",
                     $time, waited, latency);
            stop_failed();
        end
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic select_entry(input int s, input int w);
        bus_access(1'b1, REG_SELECT, {16'd0, 8'(s), 8'(w)}, 1, '0, '0, "");
    endtask

    task automatic write_entry(input int s, input int w, input llc_state_t st, input llc_tag_t tg);
        select_entry(s, w);
        bus_access(1'b1, REG_ENTRY, {10'd0, st, tg}, 1, '0, '0, "");
        state_m[s][w] = st;
        tag_m[s][w] = tg;
    endtask

    task automatic check_entry(input int s, input int w);
        select_entry(s, w);
        bus_access(1'b0, REG_ENTRY, '0, 1, '1, {10'd0, state_m[s][w], tag_m[s][w]},
                   "dat_r (ENTRY)");
    endtask

    // Mode 0 any state, 1 no INVALID, 2 all VALID, 3 all SD, 4 SHARED or SD.
    task automatic fill_set(input int s, input int mode);
        logic [31:0] r;
        llc_state_t  st;
        for (int w = 0; w < WAYS; w++) begin
            take_bits(4, r);
            case (mode)
                0: st = llc_state_t'(r[1:0]);
                1: st = (r[1:0] == 2'd0) ? SD : llc_state_t'(r[1:0]);
                2: st = VALID;
                3: st = SD;
                default: st = r[0] ? SHARED : SD;
            endcase
            write_entry(s, w, st, POOL_BASE | llc_tag_t'(r[3:2]));
        end
    endtask

    // Hit, else lowest INVALID, else first VALID, first non-SD or the pointer.
    task automatic predict(input int s, input llc_tag_t tg, output logic [31:0] res);
        int   w;
        int   v;
        logic h;
        logic ev;
        w = -1;
        h = 1'b0;
        ev = 1'b0;
        for (int i = 0; i < WAYS; i++) begin
            if (w < 0 && state_m[s][i] != INVALID && tag_m[s][i] == tg) begin
                w = i;
                h = 1'b1;
            end
        end
        for (int i = 0; i < WAYS; i++) begin
            if (w < 0 && state_m[s][i] == INVALID) w = i;
        end
        if (w < 0) begin
            ev = 1'b1;
            for (int k = 0; k < WAYS; k++) begin
                v = (ptr_m[s] + k) % WAYS;
                if (w < 0 && state_m[s][v] == VALID) w = v;
            end
            for (int k = 0; k < WAYS; k++) begin
                v = (ptr_m[s] + k) % WAYS;
                if (w < 0 && state_m[s][v] != SD) w = v;
            end
            if (w < 0) w = ptr_m[s];
            ptr_m[s] = (w + 1) % WAYS;
        end
        res = {22'd0, h, ev, 8'(w)};
    endtask

    task automatic lookup(input int s, input llc_tag_t tg);
        logic [31:0] res;
        predict(s, tg, res);
        select_entry(s, 0);
        bus_access(1'b1, REG_LOOKUP, {12'd0, tg}, 2, '0, '0, "");
        bus_access(1'b0, REG_RESULT, '0, 1, '1, res, "dat_r (RESULT)");
    endtask

    initial begin
        logic [31:0] r;
        int          s;
        int          set_q [$];
        int          way_q [$];
        rst = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        sel = '0;
        lfsr = 32'h1a0f_5995;
        exp_mask = '0;
        exp_data = '0;
        exp_name = "";
        for (int i = 0; i < SETS; i++) begin
            ptr_m[i] = 0;
            for (int w = 0; w < WAYS; w++) state_m[i][w] = INVALID;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        for (int i = 0; i < N_RESET; i++) begin   // Tags have no reset value.
            take_bits(7, r);
            select_entry(int'(r[6:3]), int'(r[2:0]));
            bus_access(1'b0, REG_SELECT, '0, 1, '1, {16'd0, 8'(r[6:3]), 8'(r[2:0])},
                       "dat_r (SELECT)");
            bus_access(1'b0, REG_ENTRY, '0, 1, 32'h0030_0000, '0, "dat_r (ENTRY state)");
        end
        for (int i = 0; i < N_RW; i++) begin
            take_bits(29, r);
            write_entry(int'(r[28:25]), int'(r[24:22]), llc_state_t'(r[21:20]), r[19:0]);
            set_q.push_back(int'(r[28:25]));
            way_q.push_back(int'(r[24:22]));
        end
        foreach (set_q[i]) check_entry(set_q[i], way_q[i]);

        fill_set(3, 1);
        write_entry(3, 0, INVALID, HIT_TAG);
        write_entry(3, 2, SHARED, HIT_TAG);
        write_entry(3, 5, VALID, HIT_TAG);
        lookup(3, HIT_TAG);
        fill_set(5, 1);
        write_entry(5, 6, INVALID, '0);
        write_entry(5, 1, INVALID, STALE_TAG);
        lookup(5, STALE_TAG);

        for (int i = 0; i < N_VICTIM; i++) begin
            take_bits(20, r);
            s = int'(r[19:16]);
            fill_set(s, i == 0 ? 3 : (i == 1 ? 4 : 1));
            lookup(s, MISS_BASE | llc_tag_t'(r[7:0]));
            lookup(s, MISS_BASE | llc_tag_t'(r[15:8]));
        end

        fill_set(9, 2);
        for (int i = 0; i < N_ROT; i++) begin
            if (i == N_ROT / 2) begin
                fill_set(10, 2);
                lookup(10, MISS_BASE);
            end
            lookup(9, MISS_BASE | llc_tag_t'(i));
        end

        for (int i = 0; i < N_MIX; i++) begin
            take_bits(6, r);
            s = int'(r[3:0]);
            fill_set(s, 0);
            lookup(s, POOL_BASE | llc_tag_t'(r[5:4]));
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module llc_lookup_tb -o llc_lookup_sim &&
./obj_dir/llc_lookup_sim | tee /dev/stderr | grep -qx "TEST PASS" &&
echo "Simulation passed." ||
{ echo "Simulation failed."; exit 1; }

// File: source/llc_lookup_top.sv
module llc_lookup_top #(
    parameter int WAYS = 8,
    parameter int SETS = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [31:0] dat_w,
    input  logic [3:0]  sel,
    output logic [31:0] dat_r,
    output logic        ack
);
    import llc_pkg::*;

    localparam int WAY_BITS = $clog2(WAYS);
    localparam int SET_BITS = $clog2(SETS);

    logic                   wr_en;
    logic [SET_BITS-1:0]    wr_set;
    logic [WAY_BITS-1:0]    wr_way;
    llc_entry_t             wr_entry;
    logic [SET_BITS-1:0]    rd_set;
    logic                   lookup_req;
    llc_tag_t               tag;
    logic                   advance;
    llc_entry_t [WAYS-1:0]  set_entries;
    logic [WAY_BITS-1:0]    evict_ptr;
    logic                   hit_found, empty_found, valid_found, not_sd_found;
    logic [WAY_BITS-1:0]    hit_way, empty_way, valid_way, not_sd_way;
    logic [WAY_BITS-1:0]    way;
    logic                   evict;
    logic                   hit;

    llc_wb_regs #(.WAYS(WAYS), .SETS(SETS)) regs0 (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack),
        .wr_en(wr_en), .wr_set(wr_set), .wr_way(wr_way), .wr_entry(wr_entry),
        .rd_set(rd_set), .lookup_req(lookup_req), .tag(tag), .advance(advance),
        .set_entries(set_entries), .way(way), .evict(evict), .hit(hit)
    );

    llc_tag_store #(.WAYS(WAYS), .SETS(SETS)) store0 (
        .clk(clk), .rst(rst), .wr_en(wr_en), .wr_set(wr_set), .wr_way(wr_way),
        .wr_entry(wr_entry), .rd_set(rd_set), .set_entries(set_entries),
        .evict_ptr(evict_ptr), .advance(advance), .advance_way(way)
    );

    // Hit and empty search runs beside the victim scan.
    tag_match #(.WAYS(WAYS)) match0 (
        .tag(tag), .set_entries(set_entries),
        .hit_found(hit_found), .hit_way(hit_way),
        .empty_found(empty_found), .empty_way(empty_way)
    );

    victim_scan #(.WAYS(WAYS)) scan0 (
        .set_entries(set_entries), .evict_ptr(evict_ptr),
        .valid_found(valid_found), .valid_way(valid_way),
        .not_sd_found(not_sd_found), .not_sd_way(not_sd_way)
    );

    lookup_way #(.WAYS(WAYS)) pick0 (
        .clk(clk), .rst(rst), .lookup_en(lookup_req), .evict_ptr(evict_ptr),
        .hit_found(hit_found), .hit_way(hit_way),
        .empty_found(empty_found), .empty_way(empty_way),
        .valid_found(valid_found), .valid_way(valid_way),
        .not_sd_found(not_sd_found), .not_sd_way(not_sd_way),
        .way(way), .evict(evict), .hit(hit)
    );

endmodule

// File: source/llc_pkg.sv
package llc_pkg;

    // Coherence state of a line.
    typedef enum logic [1:0] {
        INVALID = 2'd0,
        VALID   = 2'd1,
        SHARED  = 2'd2,
        SD      = 2'd3   // Shared-dirty.
    } llc_state_t;

    localparam int TAG_BITS = 20;

    typedef logic [TAG_BITS-1:0] llc_tag_t;

    typedef struct packed {
        llc_state_t state;
        llc_tag_t   tag;
    } llc_entry_t;

    // Entry view of the bus word.
    typedef struct packed {
        logic [31-TAG_BITS-2:0] pad;
        llc_state_t             state;
        llc_tag_t               tag;
    } llc_wb_entry_t;

    // Result view of the bus word.
    typedef struct packed {
        logic [21:0] pad;
        logic        hit;
        logic        evict;
        logic [7:0]  way;
    } llc_wb_result_t;

    typedef union packed {
        llc_wb_entry_t  entry;
        llc_wb_result_t result;
    } llc_wb_word_u;

    // Register indices, adr[3:2].
    localparam logic [1:0] REG_SELECT = 2'd0;
    localparam logic [1:0] REG_ENTRY  = 2'd1;
    localparam logic [1:0] REG_LOOKUP = 2'd2;
    localparam logic [1:0] REG_RESULT = 2'd3;

endpackage

// File: source/llc_tag_store.sv
module llc_tag_store #(
    parameter int WAYS = 8,
    parameter int SETS = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_en,
    input  logic [$clog2(SETS)-1:0]        wr_set,
    input  logic [$clog2(WAYS)-1:0]        wr_way,
    input  llc_pkg::llc_entry_t            wr_entry,
    input  logic [$clog2(SETS)-1:0]        rd_set,
    output llc_pkg::llc_entry_t [WAYS-1:0] set_entries,
    output logic [$clog2(WAYS)-1:0]        evict_ptr,
    input  logic                           advance,
    input  logic [$clog2(WAYS)-1:0]        advance_way
);
    import llc_pkg::*;

    localparam int WAY_BITS = $clog2(WAYS);
    localparam int SET_BITS = $clog2(SETS);

    llc_tag_t   [WAYS-1:0] tag_mem [SETS];
    llc_state_t [WAYS-1:0] state_q [SETS];
    logic [WAY_BITS-1:0]   ptr_q [SETS];
    logic [SET_BITS-1:0]   rd_set_q;   // Set held in set_entries.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_set][wr_way] <= wr_entry.tag;
        end
    end

    // States must come up INVALID, pointers at way 0.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    state_q[s][w] <= INVALID;
                end
                ptr_q[s] <= '0;
            end
            rd_set_q <= '0;
        end else begin
            if (wr_en) begin
                state_q[wr_set][wr_way] <= wr_entry.state;
            end
            if (advance) begin
                ptr_q[rd_set_q] <= advance_way + 1'b1;   // Wraps, WAYS is a power of two.
            end
            rd_set_q <= rd_set;
        end
    end

    // Whole set word, refreshed every cycle.
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            set_entries[w].state <= state_q[rd_set][w];
            set_entries[w].tag   <= tag_mem[rd_set][w];
        end
        evict_ptr <= ptr_q[rd_set];
    end

endmodule

// File: source/llc_wb_regs.sv
module llc_wb_regs #(
    parameter int WAYS = 8,
    parameter int SETS = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cyc,
    input  logic                           stb,
    input  logic                           we,
    input  logic [31:0]                    adr,
    input  logic [31:0]                    dat_w,
    input  logic [3:0]                     sel,
    output logic [31:0]                    dat_r,
    output logic                           ack,
    output logic                           wr_en,
    output logic [$clog2(SETS)-1:0]        wr_set,
    output logic [$clog2(WAYS)-1:0]        wr_way,
    output llc_pkg::llc_entry_t            wr_entry,
    output logic [$clog2(SETS)-1:0]        rd_set,
    output logic                           lookup_req,
    output llc_pkg::llc_tag_t              tag,
    output logic                           advance,
    input  llc_pkg::llc_entry_t [WAYS-1:0] set_entries,
    input  logic [$clog2(WAYS)-1:0]        way,
    input  logic                           evict,
    input  logic                           hit
);
    import llc_pkg::*;

    localparam int WAY_BITS = $clog2(WAYS);
    localparam int SET_BITS = $clog2(SETS);

    logic [SET_BITS-1:0] sel_set_q;
    logic [WAY_BITS-1:0] sel_way_q;
    logic [1:0]          reg_q;          // Register of the access being acked.
    logic                lookup_done_q;
    logic                req;
    logic                is_lookup;
    llc_wb_word_u        wr_word;
    llc_wb_word_u        rd_word;

    // New access; blocked while a lookup is in flight.
    assign req       = cyc && stb && !ack && !lookup_req;
    assign is_lookup = we && adr[3:2] == REG_LOOKUP;
    assign wr_word   = dat_w;

    assign wr_en          = req && we && adr[3:2] == REG_ENTRY && sel == 4'hf;
    assign wr_set         = sel_set_q;
    assign wr_way         = sel_way_q;
    assign rd_set         = sel_set_q;
    assign wr_entry.state = wr_word.entry.state;
    assign wr_entry.tag   = wr_word.entry.tag;
    assign advance        = lookup_done_q && evict;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ack           <= 1'b0;
            lookup_req    <= 1'b0;
            lookup_done_q <= 1'b0;
            sel_set_q     <= '0;
            sel_way_q     <= '0;
            reg_q         <= REG_SELECT;
        end else begin
            ack           <= (req && !is_lookup) || lookup_req;   // Lookups ack a cycle later.
            lookup_req    <= req && is_lookup;
            lookup_done_q <= lookup_req;
            if (req) begin
                reg_q <= adr[3:2];
            end
            if (req && we && adr[3:2] == REG_SELECT) begin
                sel_set_q <= dat_w[8 +: SET_BITS];
                sel_way_q <= dat_w[WAY_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && is_lookup) begin
            tag <= wr_word.entry.tag;   // Low bits of dat_w.
        end
    end

    always_comb begin
        rd_word = '0;
        case (reg_q)
            REG_SELECT: begin
                rd_word = {16'd0, 8'(sel_set_q), 8'(sel_way_q)};
            end
            REG_ENTRY: begin
                rd_word.entry.state = set_entries[sel_way_q].state;
                rd_word.entry.tag   = set_entries[sel_way_q].tag;
            end
            REG_RESULT: begin
                rd_word.result.hit   = hit;
                rd_word.result.evict = evict;
                rd_word.result.way   = 8'(way);
            end
            default: rd_word = '0;
        endcase
    end

    assign dat_r = rd_word;

endmodule

// File: source/lookup_way.sv
module lookup_way #(
    parameter int WAYS = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    lookup_en,
    input  logic [$clog2(WAYS)-1:0] evict_ptr,
    input  logic                    hit_found,
    input  logic [$clog2(WAYS)-1:0] hit_way,
    input  logic                    empty_found,
    input  logic [$clog2(WAYS)-1:0] empty_way,
    input  logic                    valid_found,
    input  logic [$clog2(WAYS)-1:0] valid_way,
    input  logic                    not_sd_found,
    input  logic [$clog2(WAYS)-1:0] not_sd_way,
    output logic [$clog2(WAYS)-1:0] way,
    output logic                    evict,
    output logic                    hit
);
    localparam int WAY_BITS = $clog2(WAYS);

    logic [WAY_BITS-1:0] way_next;
    logic                evict_next;

    always_comb begin
        evict_next = 1'b1;
        if (hit_found) begin
            way_next   = hit_way;
            evict_next = 1'b0;
        end else if (empty_found) begin
            way_next   = empty_way;
            evict_next = 1'b0;
        end else if (valid_found) begin
            way_next = valid_way;
        end else if (not_sd_found) begin
            way_next = not_sd_way;
        end else begin
            way_next = evict_ptr;   // Every way is SD.
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            way   <= '0;
            evict <= 1'b0;
            hit   <= 1'b0;
        end else if (lookup_en) begin
            way   <= way_next;
            evict <= evict_next;
            hit   <= hit_found;
        end
    end

endmodule

// File: source/tag_match.sv
module tag_match #(
    parameter int WAYS = 8
) (
    input  llc_pkg::llc_tag_t              tag,
    input  llc_pkg::llc_entry_t [WAYS-1:0] set_entries,
    output logic                           hit_found,
    output logic [$clog2(WAYS)-1:0]        hit_way,
    output logic                           empty_found,
    output logic [$clog2(WAYS)-1:0]        empty_way
);
    import llc_pkg::*;

    localparam int WAY_BITS = $clog2(WAYS);

    logic [WAYS-1:0] hit_vec;
    logic [WAYS-1:0] empty_vec;

    // Lowest set bit wins.
    function automatic logic [WAY_BITS-1:0] lowest_way(input logic [WAYS-1:0] vec);
        logic [WAY_BITS-1:0] idx;
        idx = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = WAY_BITS'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            hit_vec[i]   = set_entries[i].state != INVALID && set_entries[i].tag == tag;
            empty_vec[i] = set_entries[i].state == INVALID;
        end
    end

    assign hit_found   = |hit_vec;
    assign hit_way     = lowest_way(hit_vec);
    assign empty_found = |empty_vec;
    assign empty_way   = lowest_way(empty_vec);

endmodule

// File: source/victim_scan.sv
module victim_scan #(
    parameter int WAYS = 8
) (
    input  llc_pkg::llc_entry_t [WAYS-1:0] set_entries,
    input  logic [$clog2(WAYS)-1:0]        evict_ptr,
    output logic                           valid_found,
    output logic [$clog2(WAYS)-1:0]        valid_way,
    output logic                           not_sd_found,
    output logic [$clog2(WAYS)-1:0]        not_sd_way
);
    import llc_pkg::*;

    localparam int WAY_BITS = $clog2(WAYS);

    // Walks the offsets backwards so the one nearest the pointer is kept.
    always_comb begin
        logic [WAY_BITS-1:0] idx;
        idx          = '0;
        valid_found  = 1'b0;
        valid_way    = '0;
        not_sd_found = 1'b0;
        not_sd_way   = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            idx = evict_ptr + WAY_BITS'(i);   // Modulo WAYS.
            if (set_entries[idx].state == VALID) begin
                valid_found = 1'b1;
                valid_way   = idx;
            end
            if (set_entries[idx].state != SD) begin
                not_sd_found = 1'b1;
                not_sd_way   = idx;
            end
        end
    end

endmodule

// File: verilog.f
source/llc_pkg.sv
source/llc_tag_store.sv
source/tag_match.sv
source/victim_scan.sv
source/lookup_way.sv
source/llc_wb_regs.sv
source/llc_lookup_top.sv
bench/llc_lookup_tb.sv
